/* rtl/filterPkg.sv */
`default_nettype none

package filterPkg;

	// source image and result buffer size
	localparam int IMG_W = 32;
	localparam int IMG_H = 24;
	localparam int PIX_COUNT = IMG_W * IMG_H;

	// reduced raster timing, one pixel per clock
	localparam int H_ACTIVE = 32;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 2;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	localparam int V_ACTIVE = 24;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam int ADDR_W = 10;

	typedef logic [7:0] pixel_t;
	typedef logic [ADDR_W-1:0] pixAddr_t;
	// one extra column so IMG_W itself fits
	typedef logic [5:0] xCoord_t;
	typedef logic [4:0] yCoord_t;
	typedef logic [5:0] count_t;

	typedef enum logic [1:0] {
		KERN_IDENTITY = 2'd0,
		KERN_BLUR = 2'd1,
		KERN_SHARPEN = 2'd2,
		KERN_EDGE = 2'd3
	} kernel_t;

	// fetch position, lines up with memory data after one register
	typedef struct packed {
		logic valid;
		xCoord_t column;
		yCoord_t row;
		logic isLast;
	} fetch_t;

	// three vertically adjacent source pixels
	typedef struct packed {
		pixel_t top;
		pixel_t mid;
		pixel_t bot;
	} column_t;

	typedef struct packed {
		logic we;
		pixAddr_t addr;
		pixel_t pixel;
	} result_t;

	// wishbone classic request from the host
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		pixAddr_t adr;
		pixel_t dat;
	} wbReq_t;

	// linear address, row major
	function automatic pixAddr_t makeAddr(yCoord_t row, xCoord_t column);
		return pixAddr_t'(row) * pixAddr_t'(IMG_W) + pixAddr_t'(column);
	endfunction

endpackage

`default_nettype wire

/* rtl/kernelSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module kernelSelect import filterPkg::*; (
	input logic CLK,
	input logic reset,
	input logic identity,
	input logic kernel1,
	input logic kernel2,
	input logic kernel3,
	output kernel_t kernel
);

	// held until the next press
	// fixed priority: blur, sharpen, edge, identity
	always_ff @(posedge CLK) begin
		if (reset) begin
			kernel <= KERN_IDENTITY;
		end else if (kernel1) begin
			kernel <= KERN_BLUR;
		end else if (kernel2) begin
			kernel <= KERN_SHARPEN;
		end else if (kernel3) begin
			kernel <= KERN_EDGE;
		end else if (identity) begin
			kernel <= KERN_IDENTITY;
		end
	end

endmodule

`default_nettype wire

/* rtl/columnFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module columnFetch import filterPkg::*; (
	input logic CLK,
	input logic reset,
	output fetch_t fetch,
	output pixAddr_t addrTop,
	output pixAddr_t addrMid,
	output pixAddr_t addrBot
);

	logic running;
	xCoord_t column;
	yCoord_t row;
	logic lastColumn;
	logic lastFetch;
	xCoord_t readColumn;
	yCoord_t rowTop;
	yCoord_t rowBot;

	// column IMG_W is the flush column of each row
	assign lastColumn = (column == xCoord_t'(IMG_W));
	assign lastFetch = lastColumn && (row == yCoord_t'(IMG_H - 1));

	// first cycle after reset only arms the walk
	always_ff @(posedge CLK) begin
		if (reset) begin
			running <= 1'b0;
			column <= '0;
			row <= '0;
		end else begin
			running <= 1'b1;
			if (running) begin
				if (lastColumn) begin
					column <= '0;
					row <= lastFetch ? yCoord_t'(0) : row + 1'b1;
				end else begin
					column <= column + 1'b1;
				end
			end
		end
	end

	// clamp to the image edge
	assign readColumn = lastColumn ? xCoord_t'(IMG_W - 1) : column;
	assign rowTop = (row == '0) ? row : row - 1'b1;
	assign rowBot = (row == yCoord_t'(IMG_H - 1)) ? row : row + 1'b1;

	assign addrTop = makeAddr(rowTop, readColumn);
	assign addrMid = makeAddr(row, readColumn);
	assign addrBot = makeAddr(rowBot, readColumn);

	// unclamped position goes downstream
	assign fetch.valid = running;
	assign fetch.column = column;
	assign fetch.row = row;
	assign fetch.isLast = running && lastFetch;

endmodule

`default_nettype wire

/* rtl/frameMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module frameMemory import filterPkg::*; (
	input logic CLK,
	input logic reset,
	input pixAddr_t addrTop,
	input pixAddr_t addrMid,
	input pixAddr_t addrBot,
	output column_t column,
	input result_t result,
	input pixAddr_t dispAddr,
	output pixel_t dispPixel,
	input wbReq_t wbReq,
	output logic wbAck,
	output pixel_t wbDatOut
);

	// source image, loaded by the host
	pixel_t srcMem [PIX_COUNT];
	// filtered image, scanned by the raster
	pixel_t resMem [PIX_COUNT];

	logic wbAccess;
	logic wbInRange;

	assign wbAccess = wbReq.cyc && wbReq.stb;
	assign wbInRange = (wbReq.adr < pixAddr_t'(PIX_COUNT));

	// ack one cycle after cyc and stb, drops after stb does
	always_ff @(posedge CLK) begin
		if (reset) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= wbAccess;
		end
	end

	// host port
	// out of range writes ignored, reads give zero
	always_ff @(posedge CLK) begin
		if (wbAccess && wbReq.we && wbInRange) begin
			srcMem[wbReq.adr] <= wbReq.dat;
		end
		wbDatOut <= wbInRange ? srcMem[wbReq.adr] : pixel_t'(0);
	end

	// three filter reads, data one cycle later
	always_ff @(posedge CLK) begin
		column.top <= srcMem[addrTop];
		column.mid <= srcMem[addrMid];
		column.bot <= srcMem[addrBot];
	end

	// pipeline writes into result buffer
	always_ff @(posedge CLK) begin
		if (result.we) begin
			resMem[result.addr] <= result.pixel;
		end
	end

	// display read, one cycle latency
	always_ff @(posedge CLK) begin
		dispPixel <= resMem[dispAddr];
	end

endmodule

`default_nettype wire

/* rtl/convolve.sv */
`timescale 1ns/1ps
`default_nettype none

module convolve import filterPkg::*; (
	input logic CLK,
	input logic reset,
	input kernel_t kernel,
	input fetch_t fetchIn,
	input column_t column,
	output result_t result
);

	kernel_t frameKernel;
	fetch_t fetchD1;
	fetch_t fetchD2;
	// window, index 0 is the leftmost column
	column_t win [3];
	logic firstFetch;
	xCoord_t outColumn;
	logic border;
	logic signed [4:0] weight [3][3];
	logic [2:0] shiftAmt;
	logic signed [13:0] sum;
	logic signed [13:0] shifted;
	pixel_t clamped;

	// frame start follows the previous frame's last fetch
	assign firstFetch = fetchIn.valid && (!fetchD1.valid || fetchD1.isLast);

	always_ff @(posedge CLK) begin
		if (reset) begin
			frameKernel <= KERN_IDENTITY;
			fetchD1 <= '0;
			fetchD2 <= '0;
		end else begin
			if (firstFetch) begin
				frameKernel <= kernel;
			end
			// D1 lines up with memory data, D2 with the window
			fetchD1 <= fetchIn;
			fetchD2 <= fetchD1;
		end
	end

	// shift the new column in on the right
	always_ff @(posedge CLK) begin
		win[0] <= win[1];
		win[1] <= win[2];
		win[2] <= column;
	end

	// kernel weights and shift
	always_comb begin
		weight = '{default: 5'sd0};
		shiftAmt = 3'd0;
		case (frameKernel)
			KERN_BLUR: begin
				weight = '{'{5'sd1, 5'sd2, 5'sd1}, '{5'sd2, 5'sd4, 5'sd2}, '{5'sd1, 5'sd2, 5'sd1}};
				shiftAmt = 3'd4;
			end
			KERN_SHARPEN: begin
				weight = '{'{5'sd0, -5'sd1, 5'sd0}, '{-5'sd1, 5'sd5, -5'sd1},
					'{5'sd0, -5'sd1, 5'sd0}};
			end
			KERN_EDGE: begin
				weight = '{'{-5'sd1, -5'sd1, -5'sd1}, '{-5'sd1, 5'sd8, -5'sd1},
					'{-5'sd1, -5'sd1, -5'sd1}};
			end
			default: begin
				weight[1][1] = 5'sd1;
			end
		endcase
	end

	// weighted sum over the window, then arithmetic shift
	always_comb begin
		sum = '0;
		for (int c = 0; c < 3; c++) begin
			sum = sum + weight[0][c] * $signed({1'b0, win[c].top});
			sum = sum + weight[1][c] * $signed({1'b0, win[c].mid});
			sum = sum + weight[2][c] * $signed({1'b0, win[c].bot});
		end
		shifted = sum >>> shiftAmt;
	end

	// clamp to 0..255
	assign clamped = (shifted < 0) ? pixel_t'(0) :
		(shifted > 14'sd255) ? pixel_t'(255) : shifted[7:0];

	// centre of the window is one column behind the fetch
	assign outColumn = fetchD2.column - 1'b1;
	assign border = (fetchD2.row == '0) || (fetchD2.row == yCoord_t'(IMG_H - 1)) ||
		(outColumn == '0) || (outColumn == xCoord_t'(IMG_W - 1));

	// fetch column 0 has no output pixel yet
	always_ff @(posedge CLK) begin
		if (reset) begin
			result.we <= 1'b0;
		end else begin
			result.we <= fetchD2.valid && (fetchD2.column != '0);
		end
		result.addr <= makeAddr(fetchD2.row, outColumn);
		result.pixel <= border ? win[1].mid : clamped;
	end

endmodule

`default_nettype wire

/* rtl/rasterTiming.sv */
`timescale 1ns/1ps
`default_nettype none

module rasterTiming import filterPkg::*; (
	input logic CLK,
	input logic reset,
	output pixAddr_t dispAddr,
	input pixel_t dispPixel,
	output logic hsync,
	output logic vsync,
	output logic blank,
	output pixel_t r,
	output pixel_t g,
	output pixel_t b
);

	count_t hCount;
	count_t vCount;
	logic lineEnd;
	logic active;
	logic hsyncNext;
	logic vsyncNext;

	assign lineEnd = (hCount == count_t'(H_TOTAL - 1));

	// free running from reset
	always_ff @(posedge CLK) begin
		if (reset) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			hCount <= lineEnd ? count_t'(0) : hCount + 1'b1;
			if (lineEnd) begin
				vCount <= (vCount == count_t'(V_TOTAL - 1)) ? count_t'(0) : vCount + 1'b1;
			end
		end
	end

	assign active = (hCount < count_t'(H_ACTIVE)) && (vCount < count_t'(V_ACTIVE));

	// sync pulses low
	assign hsyncNext = !((hCount >= count_t'(H_ACTIVE + H_FRONT)) &&
		(hCount < count_t'(H_ACTIVE + H_FRONT + H_SYNC)));
	assign vsyncNext = !((vCount >= count_t'(V_ACTIVE + V_FRONT)) &&
		(vCount < count_t'(V_ACTIVE + V_FRONT + V_SYNC)));

	// address only matters while active
	assign dispAddr = active ? makeAddr(yCoord_t'(vCount), xCoord_t'(hCount)) : pixAddr_t'(0);

	// one stage to match the buffer read
	always_ff @(posedge CLK) begin
		if (reset) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank <= 1'b0;
		end else begin
			hsync <= hsyncNext;
			vsync <= vsyncNext;
			blank <= active;
		end
	end

	// grey out, black outside active video
	assign r = blank ? dispPixel : pixel_t'(0);
	assign g = blank ? dispPixel : pixel_t'(0);
	assign b = blank ? dispPixel : pixel_t'(0);

endmodule

`default_nettype wire

/* rtl/imageFilterTop.sv */
`timescale 1ns/1ps
`default_nettype none

module imageFilterTop import filterPkg::*; (
	input logic CLK,
	input logic reset,
	input logic identity,
	input logic kernel1,
	input logic kernel2,
	input logic kernel3,
	input wbReq_t wbReq,
	output logic wbAck,
	output pixel_t wbDatOut,
	output logic hsync,
	output logic vsync,
	output logic blank,
	output pixel_t r,
	output pixel_t g,
	output pixel_t b
);

	kernel_t kernel;
	fetch_t fetch;
	pixAddr_t addrTop;
	pixAddr_t addrMid;
	pixAddr_t addrBot;
	column_t column;
	result_t result;
	pixAddr_t dispAddr;
	pixel_t dispPixel;

	// button priority and hold
	kernelSelect kernelSel (.CLK, .reset, .identity, .kernel1, .kernel2, .kernel3, .kernel);

	// filter pipeline: fetch, memory, convolve
	columnFetch colFetch (.CLK, .reset, .fetch, .addrTop, .addrMid, .addrBot);

	frameMemory frameMem (.CLK, .reset, .addrTop, .addrMid, .addrBot, .column, .result,
		.dispAddr, .dispPixel, .wbReq, .wbAck, .wbDatOut);

	convolve conv (.CLK, .reset, .kernel, .fetchIn(fetch), .column, .result);

	// display scan of the result buffer
	rasterTiming raster (.CLK, .reset, .dispAddr, .dispPixel, .hsync, .vsync, .blank,
		.r, .g, .b);

endmodule

`default_nettype wire

/* tests/imageFilter_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module imageFilterChk import filterPkg::*; (
	input logic CLK,
	input logic reset,
	input wbReq_t wbReq,
	input logic wbAck,
	input logic hsync,
	input logic vsync,
	input logic blank,
	input kernel_t frameKernel,
	input fetch_t fetch
);

	// failed assertion tally for the final report
	int failCount = 0;
	count_t hsyncLow;
	logic frameStart;

	// length of the running hsync low pulse
	always_ff @(posedge CLK) begin
		if (reset) begin
			hsyncLow <= '0;
		end else if (!hsync) begin
			hsyncLow <= hsyncLow + 1'b1;
		end else begin
			hsyncLow <= '0;
		end
	end

	// top left fetch of the walk
	assign frameStart = fetch.valid && (fetch.column == '0) && (fetch.row == '0);

	// ack only in the cycle after cyc and stb
	ackFollowsStrobe: assert property (@(posedge CLK) disable iff (reset)
		wbAck |-> $past(wbReq.cyc && wbReq.stb))
	else begin
		failCount++;
		$error("wishbone ack without a preceding cycle and strobe");
	end

	// hsync pulse is exactly H_SYNC cycles low
	hsyncWidth: assert property (@(posedge CLK) disable iff (reset)
		$rose(hsync) |-> (hsyncLow == count_t'(H_SYNC)))
	else begin
		failCount++;
		$error("hsync low pulse of %0d cycles", hsyncLow);
	end

	// no active video inside vertical sync
	blankInVsync: assert property (@(posedge CLK) disable iff (reset)
		!(blank && !vsync))
	else begin
		failCount++;
		$error("active video while vsync is low");
	end

	// kernel only reloaded at the first fetch of a frame
	kernelAtFrameStart: assert property (@(posedge CLK) disable iff (reset)
		$changed(frameKernel) |-> $past(frameStart))
	else begin
		failCount++;
		$error("convolve kernel changed inside a frame");
	end

endmodule

bind imageFilterTop imageFilterChk chk (
	.CLK,
	.reset,
	.wbReq,
	.wbAck,
	.hsync,
	.vsync,
	.blank,
	.frameKernel(conv.frameKernel),
	.fetch
);

`default_nettype wire

/* tests/imageFilterTb.sv */
`timescale 1ns/1ps
`default_nettype none

module imageFilterTb import filterPkg::*; ();

	localparam int FILTER_FRAME = IMG_H * (IMG_W + 1);
	localparam int DISPLAY_FRAME = V_TOTAL * H_TOTAL;
	// load and readback, six kernel tests of five display frames, 20% margin
	localparam int CYCLE_LIMIT = (4 * PIX_COUNT + 6 * 5 * DISPLAY_FRAME) * 12 / 10;

	logic CLK;
	logic reset;
	logic identity;
	logic kernel1;
	logic kernel2;
	logic kernel3;
	wbReq_t wbReq;
	logic wbAck;
	pixel_t wbDatOut;
	logic hsync;
	logic vsync;
	logic blank;
	pixel_t r;
	pixel_t g;
	pixel_t b;

	int seed;
	int errors;
	int cycles = 0;
	pixel_t srcImage [PIX_COUNT];
	pixel_t expImage [PIX_COUNT];

	imageFilterTop DUT (.CLK, .reset, .identity, .kernel1, .kernel2, .kernel3, .wbReq, .wbAck,
		.wbDatOut, .hsync, .vsync, .blank, .r, .g, .b);

	always #4 CLK = ~CLK;

	// watchdog over the whole run
	always @(posedge CLK) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic checkPixel(input string name, input pixel_t expected, input pixel_t actual);
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic checkBus(input string name, input pixel_t expected, input pixel_t actual);
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic checkCount(input string name, input count_t expected, input count_t actual);
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// inputs change 1 ns after the edge, outputs are settled by then
	task automatic stepCycle();
		@(posedge CLK);
		#1;
	endtask

	// one classic access, two cycles when ack comes on time
	task automatic busAccess(input logic write, input pixAddr_t addr, input pixel_t data,
		output pixel_t readData);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we = write;
		wbReq.adr = addr;
		wbReq.dat = data;
		stepCycle();
		while (!wbAck) begin
			stepCycle();
		end
		readData = wbDatOut;
		wbReq.cyc = 1'b0;
		wbReq.stb = 1'b0;
		wbReq.we = 1'b0;
		stepCycle();
		if (wbAck) begin
			errors++;
			$display("ack still high after strobe dropped, address %0d", addr);
		end
	endtask

	// model weights, dy and dx from -1 to 1
	function automatic int kernelWeight(input kernel_t k, input int dy, input int dx);
		int w [3][3];
		case (k)
			KERN_BLUR: w = '{'{1, 2, 1}, '{2, 4, 2}, '{1, 2, 1}};
			KERN_SHARPEN: w = '{'{0, -1, 0}, '{-1, 5, -1}, '{0, -1, 0}};
			KERN_EDGE: w = '{'{-1, -1, -1}, '{-1, 8, -1}, '{-1, -1, -1}};
			default: w = '{'{0, 0, 0}, '{0, 1, 0}, '{0, 0, 0}};
		endcase
		return w[dy + 1][dx + 1];
	endfunction

	// expected filtered image, border pixels pass through
	task automatic buildModel(input kernel_t k);
		int sum;
		for (int y = 0; y < IMG_H; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				if (y == 0 || y == IMG_H - 1 || x == 0 || x == IMG_W - 1) begin
					expImage[y * IMG_W + x] = srcImage[y * IMG_W + x];
				end else begin
					sum = 0;
					for (int dy = -1; dy <= 1; dy++) begin
						for (int dx = -1; dx <= 1; dx++) begin
							sum = sum + kernelWeight(k, dy, dx) *
								int'(srcImage[(y + dy) * IMG_W + x + dx]);
						end
					end
					sum = sum >>> ((k == KERN_BLUR) ? 4 : 0);
					if (sum < 0) begin
						sum = 0;
					end else if (sum > 255) begin
						sum = 255;
					end
					expImage[y * IMG_W + x] = pixel_t'(sum);
				end
			end
		end
	endtask

	// one display frame between two vsync falls, checked against the model
	task automatic captureFrame(input string testName);
		logic prevHsync;
		logic prevVsync;
		int stored;
		count_t lineActive;
		count_t activeLines;
		count_t hPulses;
		logic frameDone;
		prevVsync = vsync;
		stepCycle();
		while (!(prevVsync && !vsync)) begin
			prevVsync = vsync;
			stepCycle();
		end
		stored = 0;
		lineActive = '0;
		activeLines = '0;
		hPulses = '0;
		frameDone = 1'b0;
		prevHsync = hsync;
		prevVsync = vsync;
		while (!frameDone) begin
			stepCycle();
			if (blank) begin
				if (stored < PIX_COUNT) begin
					checkPixel($sformatf("%s r at %0d", testName, stored), expImage[stored], r);
					checkPixel($sformatf("%s g at %0d", testName, stored), expImage[stored], g);
					checkPixel($sformatf("%s b at %0d", testName, stored), expImage[stored], b);
				end
				stored++;
				lineActive++;
			end else begin
				checkPixel({testName, " blanked r"}, 8'd0, r);
				checkPixel({testName, " blanked g"}, 8'd0, g);
				checkPixel({testName, " blanked b"}, 8'd0, b);
			end
			// line bookkeeping on each hsync fall
			if (prevHsync && !hsync) begin
				hPulses++;
				if (lineActive != 0) begin
					activeLines++;
					checkCount({testName, " active cycles per line"}, count_t'(H_ACTIVE),
						lineActive);
				end
				lineActive = '0;
			end
			if (prevVsync && !vsync) begin
				frameDone = 1'b1;
			end
			prevHsync = hsync;
			prevVsync = vsync;
		end
		checkCount({testName, " active lines"}, count_t'(V_ACTIVE), activeLines);
		checkCount({testName, " hsync pulses"}, count_t'(V_TOTAL), hPulses);
		if (stored != PIX_COUNT) begin
			errors++;
			$display("%s: frame had %0d active pixels instead of %0d", testName, stored, PIX_COUNT);
		end
	endtask

	// one-cycle button press, then settle and capture
	task automatic runKernelTest(input string testName, input logic pressId, input logic press1,
		input logic press2, input logic press3, input kernel_t modelKernel);
		identity = pressId;
		kernel1 = press1;
		kernel2 = press2;
		kernel3 = press3;
		stepCycle();
		identity = 1'b0;
		kernel1 = 1'b0;
		kernel2 = 1'b0;
		kernel3 = 1'b0;
		buildModel(modelKernel);
		repeat (3 * FILTER_FRAME + DISPLAY_FRAME) stepCycle();
		captureFrame(testName);
	endtask

	initial begin
		pixel_t readData;
		CLK = 1'b0;
		reset = 1'b1;
		identity = 1'b0;
		kernel1 = 1'b0;
		kernel2 = 1'b0;
		kernel3 = 1'b0;
		wbReq = '0;
		seed = 80328;
		errors = 0;
		repeat (10) @(posedge CLK);
		#1;
		// outputs in reset state
		if (blank !== 1'b0 || hsync !== 1'b1 || vsync !== 1'b1 || wbAck !== 1'b0) begin
			errors++;
			$display("after reset: blank, hsync, vsync or ack not at its idle level");
		end
		checkPixel("reset r", 8'd0, r);
		checkPixel("reset g", 8'd0, g);
		checkPixel("reset b", 8'd0, b);
		reset = 1'b0;
		// random source image over the bus, then read back
		for (int i = 0; i < PIX_COUNT; i++) begin
			srcImage[i] = pixel_t'($random(seed));
			busAccess(1'b1, pixAddr_t'(i), srcImage[i], readData);
		end
		for (int i = 0; i < PIX_COUNT; i++) begin
			busAccess(1'b0, pixAddr_t'(i), 8'd0, readData);
			checkBus($sformatf("readback %0d", i), srcImage[i], readData);
		end
		// beyond the image, write dropped and read zero
		busAccess(1'b1, pixAddr_t'(PIX_COUNT + 32), 8'hA5, readData);
		busAccess(1'b0, pixAddr_t'(PIX_COUNT + 32), 8'd0, readData);
		checkBus("out of range read", 8'd0, readData);
		runKernelTest("identity after reset", 1'b0, 1'b0, 1'b0, 1'b0, KERN_IDENTITY);
		runKernelTest("blur", 1'b0, 1'b1, 1'b0, 1'b0, KERN_BLUR);
		runKernelTest("sharpen", 1'b0, 1'b0, 1'b1, 1'b0, KERN_SHARPEN);
		runKernelTest("edge", 1'b0, 1'b0, 1'b0, 1'b1, KERN_EDGE);
		runKernelTest("blur over edge", 1'b0, 1'b1, 1'b0, 1'b1, KERN_BLUR);
		runKernelTest("identity button", 1'b1, 1'b0, 1'b0, 1'b0, KERN_IDENTITY);
		$display("check errors: %0d, assertion failures: %0d", errors, DUT.chk.failCount);
		if (errors == 0 && DUT.chk.failCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* imageFilter.f */
rtl/filterPkg.sv
rtl/kernelSelect.sv
rtl/columnFetch.sv
rtl/frameMemory.sv
rtl/convolve.sv
rtl/rasterTiming.sv
rtl/imageFilterTop.sv
tests/imageFilter_chk.sv
tests/imageFilterTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module imageFilterTb \
	-f imageFilter.f -o simImageFilter

output=$(./obj_dir/simImageFilter +verilator+error+limit+100 || true)
echo "$output"

if grep -qx "NO ERRORS" <<< "$output"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
